/* common/axis_fifo_pkg.sv */
package axis_fifo_pkg;

   // Beat geometry.
   localparam int DATA_BYTES = 4;

   // Buffer geometry.
   localparam int FIFO_DEPTH = 16;
   localparam int PTR_WIDTH  = 4;

   // Register slice configurations.
   localparam int REG_FULL   = 0;
   localparam int REG_LIGHT  = 1;
   localparam int REG_BYPASS = 2;

   // Full slice states.
   // Bit 0 doubles as the output valid.
   localparam logic [1:0] SLICE_ZERO = 2'b10;
   localparam logic [1:0] SLICE_ONE  = 2'b11;
   localparam logic [1:0] SLICE_TWO  = 2'b01;

   // One stream beat.
   typedef struct packed {
      logic [DATA_BYTES*8-1:0] tdata;
      logic [DATA_BYTES-1:0]   tkeep;
      logic                    tlast;
   } axis_beat_t;

endpackage

/* hw/axis_reg_slice.sv */
`timescale 1ns/1ps

module axis_reg_slice #(
   parameter int REG_CONFIG = axis_fifo_pkg::REG_FULL
) (
   input  logic                    ACLK,
   input  logic                    ARESET,
   input  axis_fifo_pkg::axis_beat_t s_beat_i,
   input  logic                    s_valid_i,
   output logic                    s_ready_o,
   output axis_fifo_pkg::axis_beat_t m_beat_o,
   output logic                    m_valid_o,
   input  logic                    m_ready_i
);

   generate
      if (REG_CONFIG == axis_fifo_pkg::REG_FULL) begin : g_full
         logic [1:0]                state_q;
         axis_fifo_pkg::axis_beat_t primary_q;
         axis_fifo_pkg::axis_beat_t skid_q;
         logic                      s_ready_q;
         logic                      areset_d1_q;
         logic                      s_fire;
         logic                      load_primary;
         logic                      load_from_skid;

         assign s_fire         = s_valid_i & s_ready_q;
         assign load_from_skid = (state_q == axis_fifo_pkg::SLICE_TWO);

         always_comb begin
            case (state_q)
               axis_fifo_pkg::SLICE_ZERO: load_primary = s_fire;
               axis_fifo_pkg::SLICE_ONE:  load_primary = s_fire & m_ready_i;
               axis_fifo_pkg::SLICE_TWO:  load_primary = m_ready_i;
               default:                   load_primary = 1'b0;
            endcase
         end

         // Hold off ready one cycle past reset.
         always_ff @(posedge ACLK) begin
            areset_d1_q <= ARESET;
         end

         // Payload registers.
         always_ff @(posedge ACLK) begin
            if (load_primary) begin
               if (load_from_skid) begin
                  primary_q <= skid_q;
               end else begin
                  primary_q <= s_beat_i;
               end
            end
            if (s_fire) begin
               skid_q <= s_beat_i;
            end
         end

         always_ff @(posedge ACLK) begin
            if (ARESET) begin
               state_q   <= axis_fifo_pkg::SLICE_ZERO;
               s_ready_q <= 1'b0;
            end else if (areset_d1_q) begin
               s_ready_q <= 1'b1;
            end else begin
               case (state_q)
                  axis_fifo_pkg::SLICE_ZERO: begin
                     if (s_fire) begin
                        state_q <= axis_fifo_pkg::SLICE_ONE;
                     end
                  end
                  axis_fifo_pkg::SLICE_ONE: begin
                     if (m_ready_i && !s_fire) begin
                        state_q <= axis_fifo_pkg::SLICE_ZERO;
                     end else if (!m_ready_i && s_fire) begin
                        // Second beat parks in the skid register.
                        state_q   <= axis_fifo_pkg::SLICE_TWO;
                        s_ready_q <= 1'b0;
                     end
                  end
                  axis_fifo_pkg::SLICE_TWO: begin
                     if (m_ready_i) begin
                        state_q   <= axis_fifo_pkg::SLICE_ONE;
                        s_ready_q <= 1'b1;
                     end
                  end
                  default: begin
                     state_q <= axis_fifo_pkg::SLICE_ZERO;
                  end
               endcase
            end
         end

         assign s_ready_o = s_ready_q;
         assign m_valid_o = state_q[0];
         assign m_beat_o  = primary_q;
      end else if (REG_CONFIG == axis_fifo_pkg::REG_LIGHT) begin : g_light
         axis_fifo_pkg::axis_beat_t data_q;
         logic                      s_ready_q;
         logic                      m_valid_q;
         logic                      areset_d1_q;
         logic                      s_fire;

         assign s_fire = s_valid_i & s_ready_q;

         always_ff @(posedge ACLK) begin
            areset_d1_q <= ARESET;
         end

         always_ff @(posedge ACLK) begin
            if (s_fire) begin
               data_q <= s_beat_i;
            end
         end

         // Ready and valid swap on every transfer.
         always_ff @(posedge ACLK) begin
            if (ARESET) begin
               s_ready_q <= 1'b0;
               m_valid_q <= 1'b0;
            end else if (areset_d1_q) begin
               s_ready_q <= 1'b1;
            end else if (m_valid_q && m_ready_i) begin
               s_ready_q <= 1'b1;
               m_valid_q <= 1'b0;
            end else if (s_fire) begin
               s_ready_q <= 1'b0;
               m_valid_q <= 1'b1;
            end
         end

         assign s_ready_o = s_ready_q;
         assign m_valid_o = m_valid_q;
         assign m_beat_o  = data_q;
      end else begin : g_bypass
         assign m_beat_o  = s_beat_i;
         assign m_valid_o = s_valid_i;
         assign s_ready_o = m_ready_i;
      end
   endgenerate

endmodule

/* axis_fifo/axis_fifo_buffer.sv */
`timescale 1ns/1ps

module axis_fifo_buffer (
   input  logic                      ACLK,
   input  logic                      ARESET,
   input  axis_fifo_pkg::axis_beat_t wr_beat_i,
   input  logic                      wr_valid_i,
   output logic                      wr_ready_o,
   output axis_fifo_pkg::axis_beat_t rd_beat_o,
   output logic                      rd_valid_o,
   input  logic                      rd_ready_i
);

   localparam int PW = axis_fifo_pkg::PTR_WIDTH;

   axis_fifo_pkg::axis_beat_t mem [axis_fifo_pkg::FIFO_DEPTH];

   logic [PW-1:0]             wr_ptr_q;
   logic [PW-1:0]             rd_ptr_q;
   logic [PW:0]               occ_q;
   logic [PW:0]               occ_next;
   logic                      wr_ready_q;
   axis_fifo_pkg::axis_beat_t out_beat_q;
   logic                      out_valid_q;
   logic                      wr_fire;
   logic                      rd_fire;
   logic                      mem_empty;
   logic                      load_out;

   assign wr_fire = wr_valid_i & wr_ready_q;
   assign rd_fire = out_valid_q & rd_ready_i;

   // Array never fills while the output register also holds a beat.
   assign mem_empty = (wr_ptr_q == rd_ptr_q);

   // Prefetch when the output register is free or draining.
   assign load_out = !mem_empty && (!out_valid_q || rd_ready_i);

   // Occupancy covers the array and the output register.
   always_comb begin
      case ({wr_fire, rd_fire})
         2'b10:   occ_next = occ_q + 1'b1;
         2'b01:   occ_next = occ_q - 1'b1;
         default: occ_next = occ_q;
      endcase
   end

   always_ff @(posedge ACLK) begin
      if (wr_fire) begin
         mem[wr_ptr_q] <= wr_beat_i;
      end
      if (load_out) begin
         out_beat_q <= mem[rd_ptr_q];
      end
   end

   always_ff @(posedge ACLK) begin
      if (ARESET) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         occ_q       <= '0;
         wr_ready_q  <= 1'b0;
         out_valid_q <= 1'b0;
      end else begin
         if (wr_fire) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (load_out) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (load_out) begin
            out_valid_q <= 1'b1;
         end else if (rd_fire) begin
            out_valid_q <= 1'b0;
         end
         occ_q <= occ_next;
         // Registered full flag.
         wr_ready_q <= (occ_next != (PW+1)'(axis_fifo_pkg::FIFO_DEPTH));
      end
   end

   assign wr_ready_o = wr_ready_q;
   assign rd_beat_o  = out_beat_q;
   assign rd_valid_o = out_valid_q;

endmodule

/* hw/axis_fifo_top.sv */
`timescale 1ns/1ps

module axis_fifo_top (
   input  logic                      ACLK,
   input  logic                      ARESET,
   input  axis_fifo_pkg::axis_beat_t s_axis_beat_i,
   input  logic                      s_axis_valid_i,
   output logic                      s_axis_ready_o,
   output axis_fifo_pkg::axis_beat_t m_axis_beat_o,
   output logic                      m_axis_valid_o,
   input  logic                      m_axis_ready_i
);

   // Input slice to buffer.
   axis_fifo_pkg::axis_beat_t in_beat;
   logic                      in_valid;
   logic                      in_ready;

   // Buffer to output slice.
   axis_fifo_pkg::axis_beat_t buf_beat;
   logic                      buf_valid;
   logic                      buf_ready;

   axis_reg_slice #(
      .REG_CONFIG (axis_fifo_pkg::REG_FULL)
   ) slice_in (
      .ACLK      (ACLK),
      .ARESET    (ARESET),
      .s_beat_i  (s_axis_beat_i),
      .s_valid_i (s_axis_valid_i),
      .s_ready_o (s_axis_ready_o),
      .m_beat_o  (in_beat),
      .m_valid_o (in_valid),
      .m_ready_i (in_ready)
   );

   axis_fifo_buffer buf0 (
      .ACLK       (ACLK),
      .ARESET     (ARESET),
      .wr_beat_i  (in_beat),
      .wr_valid_i (in_valid),
      .wr_ready_o (in_ready),
      .rd_beat_o  (buf_beat),
      .rd_valid_o (buf_valid),
      .rd_ready_i (buf_ready)
   );

   axis_reg_slice #(
      .REG_CONFIG (axis_fifo_pkg::REG_LIGHT)
   ) slice_out (
      .ACLK      (ACLK),
      .ARESET    (ARESET),
      .s_beat_i  (buf_beat),
      .s_valid_i (buf_valid),
      .s_ready_o (buf_ready),
      .m_beat_o  (m_axis_beat_o),
      .m_valid_o (m_axis_valid_o),
      .m_ready_i (m_axis_ready_i)
   );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic ACLK,
   output logic ARESET
);

   // 40 ns period.
   initial begin
      ACLK = 1'b0;
      forever begin
         #20 ACLK = ~ACLK;
      end
   end

   // Reset held for the first 8 rising edges.
   initial begin
      ARESET <= 1'b1;
      repeat (8) begin
         @(posedge ACLK);
      end
      ARESET <= 1'b0;
   end

endmodule

/* tests/axis_fifo_tb.sv */
`timescale 1ns/1ps

module axis_fifo_tb;

   logic                      ACLK;
   logic                      ARESET;
   axis_fifo_pkg::axis_beat_t s_axis_beat_i;
   logic                      s_axis_valid_i;
   logic                      s_axis_ready_o;
   axis_fifo_pkg::axis_beat_t m_axis_beat_o;
   logic                      m_axis_valid_o;
   logic                      m_axis_ready_i;

   // Every accepted beat not yet seen at the output.
   axis_fifo_pkg::axis_beat_t model_q[$];

   integer seed           = 32'h26e7f82c;
   string  cur_test       = "";
   int     in_count       = 0;
   int     out_count      = 0;
   int     mon_errors     = 0;
   int     main_errors    = 0;
   int     err_base       = 0;
   int     tests_passed   = 0;
   int     tests_failed   = 0;
   int     beats_to_send  = 0;
   int     corner_idx     = 0;
   bit     src_busy       = 1'b0;
   bit     last_in_ready  = 1'b0;
   bit     last_out_valid = 1'b0;

   tb_clock_gen clk0 (
      .ACLK   (ACLK),
      .ARESET (ARESET)
   );

   axis_fifo_top dut0 (
      .ACLK           (ACLK),
      .ARESET         (ARESET),
      .s_axis_beat_i  (s_axis_beat_i),
      .s_axis_valid_i (s_axis_valid_i),
      .s_axis_ready_o (s_axis_ready_o),
      .m_axis_beat_o  (m_axis_beat_o),
      .m_axis_valid_o (m_axis_valid_o),
      .m_axis_ready_i (m_axis_ready_i)
   );

   // Transfers are sampled mid-cycle, away from the driving edge.
   always @(negedge ACLK) begin : monitor
      axis_fifo_pkg::axis_beat_t exp_beat;
      if (!ARESET) begin
         if (m_axis_valid_o && m_axis_ready_i) begin
            out_count++;
            if (model_q.size() == 0) begin
               $display("%s: output beat appeared with no input beat outstanding", cur_test);
               mon_errors++;
            end else begin
               exp_beat = model_q.pop_front();
               if (m_axis_beat_o.tdata != exp_beat.tdata) begin
                  $display("ERROR %s: tdata expected %h, actual %h",
                           cur_test, exp_beat.tdata, m_axis_beat_o.tdata);
                  mon_errors++;
               end
               if (m_axis_beat_o.tkeep != exp_beat.tkeep) begin
                  $display("ERROR %s: tkeep expected %h, actual %h",
                           cur_test, exp_beat.tkeep, m_axis_beat_o.tkeep);
                  mon_errors++;
               end
               if (m_axis_beat_o.tlast != exp_beat.tlast) begin
                  $display("ERROR %s: tlast expected %b, actual %b",
                           cur_test, exp_beat.tlast, m_axis_beat_o.tlast);
                  mon_errors++;
               end
            end
         end
         if (s_axis_valid_i && s_axis_ready_o) begin
            model_q.push_back(s_axis_beat_i);
            in_count++;
         end
      end
   end

   // Beats held by the full slice, the buffer and the light slice.
   function automatic int top_capacity();
      return 2 + axis_fifo_pkg::FIFO_DEPTH + 1;
   endfunction

   function automatic int rand_pct();
      return $unsigned($random(seed)) % 100;
   endfunction

   // Random beat, or one from the corner patterns with tlast set.
   function automatic axis_fifo_pkg::axis_beat_t make_beat(input bit corner);
      axis_fifo_pkg::axis_beat_t beat;
      logic [31:0]               rnd;
      rnd        = $random(seed);
      beat.tdata = $random(seed);
      beat.tkeep = rnd[3:0];
      beat.tlast = rnd[4];
      if (corner) begin
         case (corner_idx % 4)
            0:       beat.tkeep = 4'hf;
            1:       beat.tkeep = 4'h0;
            2:       beat.tkeep = 4'h1;
            default: beat.tkeep = 4'h8;
         endcase
         case (corner_idx % 5)
            0:       beat.tdata = 32'h0000_0000;
            1:       beat.tdata = 32'hffff_ffff;
            2:       beat.tdata = 32'haaaa_aaaa;
            3:       beat.tdata = 32'h5555_5555;
            default: ;
         endcase
         beat.tlast = 1'b1;
         corner_idx++;
      end
      return beat;
   endfunction

   task automatic report_mismatch(input string what, input int expected, input int actual);
      $display("ERROR %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
      main_errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("%s: %s", cur_test, msg);
      main_errors++;
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      err_base = mon_errors + main_errors;
   endtask

   task automatic end_test();
      int errs;
      errs = mon_errors + main_errors - err_base;
      if (errs == 0) begin
         $display("PASS %s", cur_test);
         tests_passed++;
      end else begin
         $display("FAIL %s with %0d errors", cur_test, errs);
         tests_failed++;
      end
   endtask

   // One clock of source and sink activity.
   task automatic traffic_cycle(input int valid_pct, input int ready_pct, input bit corner);
      bit accepted;
      @(negedge ACLK);
      accepted       = src_busy && s_axis_ready_o;
      last_in_ready  = s_axis_ready_o;
      last_out_valid = m_axis_valid_o;
      @(posedge ACLK);
      if (accepted) begin
         src_busy = 1'b0;
      end
      if (!src_busy) begin
         if (beats_to_send > 0 && rand_pct() < valid_pct) begin
            s_axis_beat_i  <= make_beat(corner);
            s_axis_valid_i <= 1'b1;
            src_busy       = 1'b1;
            beats_to_send--;
         end else begin
            s_axis_valid_i <= 1'b0;
         end
      end
      m_axis_ready_i <= (rand_pct() < ready_pct);
   endtask

   task automatic send_beats(input int count, input int valid_pct, input int ready_pct,
                             input bit corner);
      int cycles;
      cycles        = 0;
      beats_to_send = count;
      while ((beats_to_send > 0 || src_busy) && cycles < 20 * count) begin
         traffic_cycle(valid_pct, ready_pct, corner);
         cycles++;
      end
      if (beats_to_send > 0 || src_busy) begin
         report_problem("source timed out before all beats were accepted");
      end
   endtask

   // Stop offering new beats and let everything in flight leave.
   task automatic wait_drain(input int limit);
      int cycles;
      cycles        = 0;
      beats_to_send = 0;
      while ((src_busy || model_q.size() != 0) && cycles < limit) begin
         traffic_cycle(0, 100, 1'b0);
         cycles++;
      end
      if (src_busy || model_q.size() != 0) begin
         report_problem($sformatf("drain timed out with %0d beats in flight", model_q.size()));
      end
   endtask

   task automatic check_reset();
      int cycles;
      begin_test("reset_state");
      cycles = 0;
      @(negedge ACLK);
      while (ARESET && cycles < 20) begin
         if (m_axis_valid_o !== 1'b0) begin
            report_mismatch("m_axis_valid_o in reset", 0, {31'd0, m_axis_valid_o});
         end
         if (s_axis_ready_o !== 1'b0) begin
            report_mismatch("s_axis_ready_o in reset", 0, {31'd0, s_axis_ready_o});
         end
         @(negedge ACLK);
         cycles++;
      end
      if (ARESET) begin
         report_problem("reset was never released");
      end
      cycles = 0;
      while (s_axis_ready_o !== 1'b1 && cycles < 10) begin
         @(negedge ACLK);
         cycles++;
      end
      if (s_axis_ready_o !== 1'b1) begin
         report_problem("s_axis_ready_o did not rise after reset");
      end
      @(posedge ACLK);
      end_test();
   endtask

   task automatic check_stream_order();
      int in_start;
      int out_start;
      begin_test("stream_order");
      in_start  = in_count;
      out_start = out_count;
      send_beats(500, 70, 100, 1'b0);
      wait_drain(200);
      if (in_count - in_start != 500) begin
         report_mismatch("accepted beats", 500, in_count - in_start);
      end
      if (out_count - out_start != 500) begin
         report_mismatch("delivered beats", 500, out_count - out_start);
      end
      end_test();
   endtask

   task automatic check_backpressure();
      int in_start;
      int out_start;
      begin_test("backpressure");
      in_start      = in_count;
      out_start     = out_count;
      beats_to_send = 1000;
      for (int i = 0; i < 1000; i++) begin
         traffic_cycle(60, 50, 1'b0);
      end
      wait_drain(500);
      if (in_count == in_start) begin
         report_problem("no beats were accepted");
      end
      if (out_count - out_start != in_count - in_start) begin
         report_mismatch("delivered beats", in_count - in_start, out_count - out_start);
      end
      end_test();
   endtask

   task automatic check_capacity();
      int in_start;
      int out_start;
      int low_run;
      int cycles;
      begin_test("capacity");
      in_start      = in_count;
      out_start     = out_count;
      beats_to_send = 100;
      low_run       = 0;
      cycles        = 0;
      while (low_run < 20 && cycles < 300) begin
         traffic_cycle(100, 0, 1'b0);
         if (last_in_ready) begin
            low_run = 0;
         end else begin
            low_run++;
         end
         cycles++;
      end
      if (low_run < 20) begin
         report_problem("s_axis_ready_o never stayed low with the sink stalled");
      end
      if (in_count - in_start != top_capacity()) begin
         report_mismatch("accepted beats", top_capacity(), in_count - in_start);
      end
      if (out_count != out_start) begin
         report_mismatch("delivered beats", 0, out_count - out_start);
      end
      // Source withdraws the offer that was never taken.
      s_axis_valid_i <= 1'b0;
      src_busy       = 1'b0;
      beats_to_send  = 0;
      end_test();
   endtask

   task automatic check_drain_after_full();
      int out_start;
      int cycles;
      begin_test("drain_after_full");
      out_start = out_count;
      cycles    = 0;
      while (out_count - out_start < top_capacity() && cycles < 200) begin
         traffic_cycle(0, 100, 1'b0);
         cycles++;
      end
      if (out_count - out_start < top_capacity()) begin
         report_problem("stored beats did not drain in time");
      end
      cycles = 0;
      while (last_out_valid && cycles < 10) begin
         traffic_cycle(0, 100, 1'b0);
         cycles++;
      end
      if (last_out_valid) begin
         report_problem("m_axis_valid_o stayed high after the drain");
      end
      // Nothing more may follow.
      repeat (10) begin
         traffic_cycle(0, 100, 1'b0);
      end
      if (out_count - out_start != top_capacity()) begin
         report_mismatch("delivered beats", top_capacity(), out_count - out_start);
      end
      if (model_q.size() != 0) begin
         report_mismatch("beats left in model", 0, model_q.size());
      end
      end_test();
   endtask

   task automatic check_payload_integrity();
      int in_start;
      int out_start;
      begin_test("payload_integrity");
      in_start  = in_count;
      out_start = out_count;
      send_beats(200, 80, 60, 1'b1);
      wait_drain(500);
      if (out_count - out_start != 200) begin
         report_mismatch("delivered beats", 200, out_count - out_start);
      end
      if (in_count - in_start != 200) begin
         report_mismatch("accepted beats", 200, in_count - in_start);
      end
      end_test();
   endtask

   initial begin : main
      s_axis_beat_i  <= '0;
      s_axis_valid_i <= 1'b0;
      m_axis_ready_i <= 1'b0;
      check_reset();
      check_stream_order();
      check_backpressure();
      check_capacity();
      check_drain_after_full();
      check_payload_integrity();
      $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, mon_errors + main_errors);
      if (tests_failed == 0 && mon_errors + main_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* build.f */
common/axis_fifo_pkg.sv
hw/axis_reg_slice.sv
axis_fifo/axis_fifo_buffer.sv
hw/axis_fifo_top.sv
tests/tb_clock_gen.sv
tests/axis_fifo_tb.sv

/* Makefile */
# Verilator build and run of the AXI4-Stream FIFO testbench.
SIM = obj_dir/axis_fifo_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		--top-module axis_fifo_tb -f build.f -o axis_fifo_sim

# The run fails unless the log holds the pass line.
run: compile
	./$(SIM) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
